//--- rs_cfg_pkg.sv
`default_nettype none

package rs_cfg_pkg;

    localparam int RS_DEPTH     = 16;
    localparam int RS_IDX_W     = 4;   // log2 of RS_DEPTH
    localparam int ISSUE_WINDOW = 4;   // entries from head seen by select
    localparam int TAG_W        = 8;   // physical register tag
    localparam int NUM_WB       = 3;   // result broadcast ports

    // four-phase req/ack sequencing on the dispatch and issue sides
    typedef enum logic [1:0] {
        HS_IDLE    = 2'd0,
        HS_ACTIVE  = 2'd1,   // req and ack both high
        HS_RELEASE = 2'd2    // waiting for the other side to drop
    } hs_state_e;

endpackage

`default_nettype wire

//--- ls_inst_pkg.sv
`default_nettype none

package ls_inst_pkg;

    localparam int INST_NUM_W = 16;
    localparam int IMM_W      = 12;

    typedef enum logic {
        LS_LOAD  = 1'b0,
        LS_STORE = 1'b1
    } ls_op_e;

    // encodings follow funct3 of the RV32I load/store group
    typedef enum logic [2:0] {
        LS_BYTE   = 3'b000,
        LS_HALF   = 3'b001,
        LS_WORD   = 3'b010,
        LS_BYTE_U = 3'b100,
        LS_HALF_U = 3'b101
    } ls_size_e;

endpackage

`default_nettype wire

//--- rs_dispatch_in.sv
`default_nettype none

module rs_dispatch_in (
    input  logic                                                  clk,
    input  logic                                                  rst_n,
    input  logic                                                  disp_req,
    input  logic [ls_inst_pkg::INST_NUM_W-1:0]                    disp_inst_num,
    input  logic [rs_cfg_pkg::TAG_W-1:0]                          disp_rd,
    input  ls_inst_pkg::ls_op_e                                   disp_op,
    input  ls_inst_pkg::ls_size_e                                 disp_size,
    input  logic [ls_inst_pkg::IMM_W-1:0]                         disp_imm,
    input  logic [rs_cfg_pkg::TAG_W-1:0]                          disp_src1,
    input  logic [rs_cfg_pkg::TAG_W-1:0]                          disp_src2,
    input  logic                                                  disp_src1_rdy,
    input  logic                                                  disp_src2_rdy,
    input  logic                                                  full,
    input  logic [rs_cfg_pkg::NUM_WB-1:0]                         wb_valid,
    input  logic [rs_cfg_pkg::NUM_WB-1:0][rs_cfg_pkg::TAG_W-1:0]  wb_tag,
    output logic                                                  disp_ack,
    output logic                                                  ent_wr,
    output logic [ls_inst_pkg::INST_NUM_W-1:0]                    ent_inst_num,
    output logic [rs_cfg_pkg::TAG_W-1:0]                          ent_rd,
    output ls_inst_pkg::ls_op_e                                   ent_op,
    output ls_inst_pkg::ls_size_e                                 ent_size,
    output logic [ls_inst_pkg::IMM_W-1:0]                         ent_imm,
    output logic [rs_cfg_pkg::TAG_W-1:0]                          ent_src1,
    output logic [rs_cfg_pkg::TAG_W-1:0]                          ent_src2,
    output logic                                                  ent_src1_rdy,
    output logic                                                  ent_src2_rdy
);

    rs_cfg_pkg::hs_state_e state_q;
    logic                  src1_hit;
    logic                  src2_hit;

    // a result landing in the accept cycle would be missed by the store
    always_comb begin
        src1_hit = 1'b0;
        src2_hit = 1'b0;
        for (int p = 0; p < rs_cfg_pkg::NUM_WB; p++) begin
            src1_hit |= wb_valid[p] && (wb_tag[p] == disp_src1);
            src2_hit |= wb_valid[p] && (wb_tag[p] == disp_src2);
        end
    end

    assign ent_wr   = (state_q == rs_cfg_pkg::HS_IDLE) && disp_req && !full;
    assign disp_ack = (state_q == rs_cfg_pkg::HS_ACTIVE);

    assign ent_inst_num = disp_inst_num;   // upstream holds fields while req is high
    assign ent_rd       = disp_rd;
    assign ent_op       = disp_op;
    assign ent_size     = disp_size;
    assign ent_imm      = disp_imm;
    assign ent_src1     = disp_src1;
    assign ent_src2     = disp_src2;
    assign ent_src1_rdy = disp_src1_rdy || src1_hit;
    assign ent_src2_rdy = disp_src2_rdy || src2_hit;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= rs_cfg_pkg::HS_IDLE;
        end else begin
            case (state_q)
                rs_cfg_pkg::HS_IDLE: begin
                    if (ent_wr) begin
                        state_q <= rs_cfg_pkg::HS_ACTIVE;
                    end
                end
                rs_cfg_pkg::HS_ACTIVE: begin
                    if (!disp_req) begin
                        state_q <= rs_cfg_pkg::HS_RELEASE;   // ack drops here
                    end
                end
                default: state_q <= rs_cfg_pkg::HS_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rs_entry_store.sv
`default_nettype none

module rs_entry_store (
    input  logic                                                  clk,
    input  logic                                                  rst_n,
    input  logic                                                  flush,
    input  logic                                                  ent_wr,
    input  logic [ls_inst_pkg::INST_NUM_W-1:0]                    ent_inst_num,
    input  logic [rs_cfg_pkg::TAG_W-1:0]                          ent_rd,
    input  ls_inst_pkg::ls_op_e                                   ent_op,
    input  ls_inst_pkg::ls_size_e                                 ent_size,
    input  logic [ls_inst_pkg::IMM_W-1:0]                         ent_imm,
    input  logic [rs_cfg_pkg::TAG_W-1:0]                          ent_src1,
    input  logic [rs_cfg_pkg::TAG_W-1:0]                          ent_src2,
    input  logic                                                  ent_src1_rdy,
    input  logic                                                  ent_src2_rdy,
    input  logic [rs_cfg_pkg::NUM_WB-1:0]                         wb_valid,
    input  logic [rs_cfg_pkg::NUM_WB-1:0][rs_cfg_pkg::TAG_W-1:0]  wb_tag,
    input  logic                                                  out_ready,
    output logic                                                  full,
    output logic                                                  sel_valid,
    output logic [ls_inst_pkg::INST_NUM_W-1:0]                    sel_inst_num,
    output logic [rs_cfg_pkg::TAG_W-1:0]                          sel_rd,
    output ls_inst_pkg::ls_op_e                                   sel_op,
    output ls_inst_pkg::ls_size_e                                 sel_size,
    output logic [ls_inst_pkg::IMM_W-1:0]                         sel_imm,
    output logic [rs_cfg_pkg::TAG_W-1:0]                          sel_src1,
    output logic [rs_cfg_pkg::TAG_W-1:0]                          sel_src2
);

    // payload
    logic [ls_inst_pkg::INST_NUM_W-1:0] inst_num_q [rs_cfg_pkg::RS_DEPTH];
    logic [rs_cfg_pkg::TAG_W-1:0]       rd_q       [rs_cfg_pkg::RS_DEPTH];
    ls_inst_pkg::ls_op_e                op_q       [rs_cfg_pkg::RS_DEPTH];
    ls_inst_pkg::ls_size_e              size_q     [rs_cfg_pkg::RS_DEPTH];
    logic [ls_inst_pkg::IMM_W-1:0]      imm_q      [rs_cfg_pkg::RS_DEPTH];
    logic [rs_cfg_pkg::TAG_W-1:0]       src1_q     [rs_cfg_pkg::RS_DEPTH];
    logic [rs_cfg_pkg::TAG_W-1:0]       src2_q     [rs_cfg_pkg::RS_DEPTH];

    logic [rs_cfg_pkg::RS_DEPTH-1:0]    valid_q;
    logic [rs_cfg_pkg::RS_DEPTH-1:0]    rdy1_q;
    logic [rs_cfg_pkg::RS_DEPTH-1:0]    rdy2_q;
    logic [rs_cfg_pkg::RS_DEPTH-1:0]    issuable;

    // pointers carry one wrap bit above the index
    logic [rs_cfg_pkg::RS_IDX_W:0]      head_q;
    logic [rs_cfg_pkg::RS_IDX_W:0]      tail_q;
    logic [rs_cfg_pkg::RS_IDX_W:0]      occupancy;
    logic [rs_cfg_pkg::RS_IDX_W-1:0]    head_idx;
    logic [rs_cfg_pkg::RS_IDX_W-1:0]    tail_idx;
    logic [rs_cfg_pkg::RS_IDX_W-1:0]    sel_idx;
    logic                               sel_found;

    assign head_idx  = head_q[rs_cfg_pkg::RS_IDX_W-1:0];
    assign tail_idx  = tail_q[rs_cfg_pkg::RS_IDX_W-1:0];
    assign occupancy = tail_q - head_q;   // modulo the pointer width
    assign full      = occupancy == rs_cfg_pkg::RS_DEPTH;
    assign issuable  = valid_q & rdy1_q & rdy2_q;

    // oldest issuable entry within the window
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = head_idx;
        for (int w = 0; w < rs_cfg_pkg::ISSUE_WINDOW; w++) begin
            logic [rs_cfg_pkg::RS_IDX_W-1:0] idx;
            idx = head_idx + w[rs_cfg_pkg::RS_IDX_W-1:0];
            if (!sel_found && issuable[idx]) begin
                sel_found = 1'b1;
                sel_idx   = idx;
            end
        end
    end

    assign sel_valid    = sel_found && out_ready;
    assign sel_inst_num = inst_num_q[sel_idx];
    assign sel_rd       = rd_q[sel_idx];
    assign sel_op       = op_q[sel_idx];
    assign sel_size     = size_q[sel_idx];
    assign sel_imm      = imm_q[sel_idx];
    assign sel_src1     = src1_q[sel_idx];
    assign sel_src2     = src2_q[sel_idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            rdy1_q  <= '0;
            rdy2_q  <= '0;
            head_q  <= '0;
            tail_q  <= '0;
        end else if (flush) begin
            valid_q <= '0;   // exception or return drops everything
            rdy1_q  <= '0;
            rdy2_q  <= '0;
            head_q  <= '0;
            tail_q  <= '0;
        end else begin
            for (int i = 0; i < rs_cfg_pkg::RS_DEPTH; i++) begin
                for (int p = 0; p < rs_cfg_pkg::NUM_WB; p++) begin
                    if (wb_valid[p] && src1_q[i] == wb_tag[p]) begin
                        rdy1_q[i] <= 1'b1;
                    end
                    if (wb_valid[p] && src2_q[i] == wb_tag[p]) begin
                        rdy2_q[i] <= 1'b1;
                    end
                end
            end
            if (sel_valid) begin
                valid_q[sel_idx] <= 1'b0;
            end
            // step past one issued slot per cycle
            if (head_q != tail_q && !valid_q[head_idx]) begin
                head_q <= head_q + 1'b1;
            end
            if (ent_wr) begin
                valid_q[tail_idx] <= 1'b1;
                rdy1_q[tail_idx]  <= ent_src1_rdy;   // overrides the wakeup above
                rdy2_q[tail_idx]  <= ent_src2_rdy;
                tail_q            <= tail_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ent_wr) begin
            inst_num_q[tail_idx] <= ent_inst_num;
            rd_q[tail_idx]       <= ent_rd;
            op_q[tail_idx]       <= ent_op;
            size_q[tail_idx]     <= ent_size;
            imm_q[tail_idx]      <= ent_imm;
            src1_q[tail_idx]     <= ent_src1;
            src2_q[tail_idx]     <= ent_src2;
        end
    end

endmodule

`default_nettype wire

//--- rs_issue_out.sv
`default_nettype none

module rs_issue_out (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               sel_valid,
    input  logic [ls_inst_pkg::INST_NUM_W-1:0] sel_inst_num,
    input  logic [rs_cfg_pkg::TAG_W-1:0]       sel_rd,
    input  ls_inst_pkg::ls_op_e                sel_op,
    input  ls_inst_pkg::ls_size_e              sel_size,
    input  logic [ls_inst_pkg::IMM_W-1:0]      sel_imm,
    input  logic [rs_cfg_pkg::TAG_W-1:0]       sel_src1,
    input  logic [rs_cfg_pkg::TAG_W-1:0]       sel_src2,
    input  logic                               iss_ack,
    output logic                               out_ready,
    output logic                               iss_req,
    output logic [ls_inst_pkg::INST_NUM_W-1:0] iss_inst_num,
    output logic [rs_cfg_pkg::TAG_W-1:0]       iss_rd,
    output ls_inst_pkg::ls_op_e                iss_op,
    output ls_inst_pkg::ls_size_e              iss_size,
    output logic [ls_inst_pkg::IMM_W-1:0]      iss_imm,
    output logic [rs_cfg_pkg::TAG_W-1:0]       iss_src1,
    output logic [rs_cfg_pkg::TAG_W-1:0]       iss_src2
);

    rs_cfg_pkg::hs_state_e state_q;

    assign out_ready = (state_q == rs_cfg_pkg::HS_IDLE);   // select stalls otherwise
    assign iss_req   = (state_q == rs_cfg_pkg::HS_ACTIVE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= rs_cfg_pkg::HS_IDLE;
        end else begin
            case (state_q)
                rs_cfg_pkg::HS_IDLE: begin
                    if (sel_valid) begin
                        state_q <= rs_cfg_pkg::HS_ACTIVE;
                    end
                end
                rs_cfg_pkg::HS_ACTIVE: begin
                    if (iss_ack) begin
                        state_q <= rs_cfg_pkg::HS_RELEASE;
                    end
                end
                rs_cfg_pkg::HS_RELEASE: begin
                    if (!iss_ack) begin
                        state_q <= rs_cfg_pkg::HS_IDLE;
                    end
                end
                default: state_q <= rs_cfg_pkg::HS_IDLE;
            endcase
        end
    end

    // captured only in idle, so fields hold for the whole handshake
    always_ff @(posedge clk) begin
        if (out_ready && sel_valid) begin
            iss_inst_num <= sel_inst_num;
            iss_rd       <= sel_rd;
            iss_op       <= sel_op;
            iss_size     <= sel_size;
            iss_imm      <= sel_imm;
            iss_src1     <= sel_src1;
            iss_src2     <= sel_src2;
        end
    end

endmodule

`default_nettype wire

//--- rs_ls_top.sv
`default_nettype none

module rs_ls_top (
    input  logic                                                  clk,
    input  logic                                                  rst_n,
    input  logic                                                  flush,
    input  logic                                                  disp_req,
    output logic                                                  disp_ack,
    input  logic [ls_inst_pkg::INST_NUM_W-1:0]                    disp_inst_num,
    input  logic [rs_cfg_pkg::TAG_W-1:0]                          disp_rd,
    input  ls_inst_pkg::ls_op_e                                   disp_op,
    input  ls_inst_pkg::ls_size_e                                 disp_size,
    input  logic [ls_inst_pkg::IMM_W-1:0]                         disp_imm,
    input  logic [rs_cfg_pkg::TAG_W-1:0]                          disp_src1,
    input  logic [rs_cfg_pkg::TAG_W-1:0]                          disp_src2,
    input  logic                                                  disp_src1_rdy,
    input  logic                                                  disp_src2_rdy,
    input  logic [rs_cfg_pkg::NUM_WB-1:0]                         wb_valid,
    input  logic [rs_cfg_pkg::NUM_WB-1:0][rs_cfg_pkg::TAG_W-1:0]  wb_tag,
    output logic                                                  iss_req,
    input  logic                                                  iss_ack,
    output logic [ls_inst_pkg::INST_NUM_W-1:0]                    iss_inst_num,
    output logic [rs_cfg_pkg::TAG_W-1:0]                          iss_rd,
    output ls_inst_pkg::ls_op_e                                   iss_op,
    output ls_inst_pkg::ls_size_e                                 iss_size,
    output logic [ls_inst_pkg::IMM_W-1:0]                         iss_imm,
    output logic [rs_cfg_pkg::TAG_W-1:0]                          iss_src1,
    output logic [rs_cfg_pkg::TAG_W-1:0]                          iss_src2
);

    // dispatch side to store
    logic                               ent_wr;
    logic [ls_inst_pkg::INST_NUM_W-1:0] ent_inst_num;
    logic [rs_cfg_pkg::TAG_W-1:0]       ent_rd;
    ls_inst_pkg::ls_op_e                ent_op;
    ls_inst_pkg::ls_size_e              ent_size;
    logic [ls_inst_pkg::IMM_W-1:0]      ent_imm;
    logic [rs_cfg_pkg::TAG_W-1:0]       ent_src1;
    logic [rs_cfg_pkg::TAG_W-1:0]       ent_src2;
    logic                               ent_src1_rdy;
    logic                               ent_src2_rdy;
    logic                               full;

    // store to issue side
    logic                               sel_valid;
    logic [ls_inst_pkg::INST_NUM_W-1:0] sel_inst_num;
    logic [rs_cfg_pkg::TAG_W-1:0]       sel_rd;
    ls_inst_pkg::ls_op_e                sel_op;
    ls_inst_pkg::ls_size_e              sel_size;
    logic [ls_inst_pkg::IMM_W-1:0]      sel_imm;
    logic [rs_cfg_pkg::TAG_W-1:0]       sel_src1;
    logic [rs_cfg_pkg::TAG_W-1:0]       sel_src2;
    logic                               out_ready;

    rs_dispatch_in u_dispatch_in (.*);

    rs_entry_store u_entry_store (.*);

    rs_issue_out u_issue_out (.*);

endmodule

`default_nettype wire

//--- rs_ls_sva.sv
`default_nettype none

module rs_ls_sva (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               disp_req,
    input  logic                               disp_ack,
    input  logic                               iss_req,
    input  logic                               iss_ack,
    input  logic [ls_inst_pkg::INST_NUM_W-1:0] iss_inst_num,
    input  logic [rs_cfg_pkg::TAG_W-1:0]       iss_rd,
    input  ls_inst_pkg::ls_op_e                iss_op,
    input  ls_inst_pkg::ls_size_e              iss_size,
    input  logic [ls_inst_pkg::IMM_W-1:0]      iss_imm,
    input  logic [rs_cfg_pkg::TAG_W-1:0]       iss_src1,
    input  logic [rs_cfg_pkg::TAG_W-1:0]       iss_src2
);

    int fail_cnt = 0;

    // payload may not move while the load/store unit has not answered
    a_iss_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (iss_req && !iss_ack) |=> $stable(iss_inst_num) && $stable(iss_rd)
            && $stable(iss_op) && $stable(iss_size) && $stable(iss_imm)
            && $stable(iss_src1) && $stable(iss_src2))
        else begin
            fail_cnt++;
            $error("issue fields changed while iss_req waited for iss_ack");
        end

    a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(disp_ack) |-> $past(disp_req))
        else begin
            fail_cnt++;
            $error("disp_ack rose without a dispatch request");
        end

    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(iss_req) |-> $past(iss_ack))   // req waits for ack in four-phase
        else begin
            fail_cnt++;
            $error("iss_req dropped before iss_ack was seen");
        end

endmodule

bind rs_ls_top rs_ls_sva u_sva (.*);

`default_nettype wire

//--- tb_rs_ls.sv
`default_nettype none

module tb_rs_ls;

    int wait_limit = 200;   // cycles before a handshake wait gives up

    logic                                                  clk;
    logic                                                  rst_n;
    logic                                                  flush;
    logic                                                  disp_req;
    logic                                                  disp_ack;
    logic [ls_inst_pkg::INST_NUM_W-1:0]                    disp_inst_num;
    logic [rs_cfg_pkg::TAG_W-1:0]                          disp_rd;
    ls_inst_pkg::ls_op_e                                   disp_op;
    ls_inst_pkg::ls_size_e                                 disp_size;
    logic [ls_inst_pkg::IMM_W-1:0]                         disp_imm;
    logic [rs_cfg_pkg::TAG_W-1:0]                          disp_src1;
    logic [rs_cfg_pkg::TAG_W-1:0]                          disp_src2;
    logic                                                  disp_src1_rdy;
    logic                                                  disp_src2_rdy;
    logic [rs_cfg_pkg::NUM_WB-1:0]                         wb_valid;
    logic [rs_cfg_pkg::NUM_WB-1:0][rs_cfg_pkg::TAG_W-1:0]  wb_tag;
    logic                                                  iss_req;
    logic                                                  iss_ack;
    logic [ls_inst_pkg::INST_NUM_W-1:0]                    iss_inst_num;
    logic [rs_cfg_pkg::TAG_W-1:0]                          iss_rd;
    ls_inst_pkg::ls_op_e                                   iss_op;
    ls_inst_pkg::ls_size_e                                 iss_size;
    logic [ls_inst_pkg::IMM_W-1:0]                         iss_imm;
    logic [rs_cfg_pkg::TAG_W-1:0]                          iss_src1;
    logic [rs_cfg_pkg::TAG_W-1:0]                          iss_src2;

    rs_ls_top DUT (.*);

    always #5 clk = ~clk;

    // inputs change and outputs are read 1 unit after the rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Error in %s: expected %0h, actual %0h", name, exp, act);
            $display("CHECKS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1, "run aborted");
    endtask

    always @(posedge clk) begin
        if (DUT.u_sva.fail_cnt != 0) begin
            abort_run("a handshake assertion on the station failed");
        end
    end

    task automatic dispatch(input string name, input logic blocked, input logic with_wb,
                            input int port, input logic [rs_cfg_pkg::TAG_W-1:0] tag);
        int n;
        disp_req = 1'b1;
        if (with_wb) begin
            wb_valid[port] = 1'b1;   // lands in the accept cycle
            wb_tag[port]   = tag;
        end
        step();
        wb_valid = '0;
        if (blocked) begin
            for (n = 0; n < 20; n++) begin
                check_eq({name, " disp_ack while full"}, 0, disp_ack);
                step();
            end
            disp_req = 1'b0;
            step();
        end else begin
            n = 0;
            while (!disp_ack) begin
                if (n == wait_limit) begin
                    abort_run({"timeout waiting for disp_ack to rise at ", name});
                end
                step();
                n++;
            end
            disp_req = 1'b0;
            n = 0;
            while (disp_ack) begin
                if (n == wait_limit) begin
                    abort_run({"timeout waiting for disp_ack to drop at ", name});
                end
                step();
                n++;
            end
            step();   // dispatch side passes through release before idle
        end
    endtask

    task automatic broadcast(input int port, input logic [rs_cfg_pkg::TAG_W-1:0] tag);
        wb_valid[port] = 1'b1;
        wb_tag[port]   = tag;
        step();
        wb_valid = '0;
    endtask

    task automatic flush_station();
        flush = 1'b1;
        step();
        flush = 1'b0;
    endtask

    task automatic expect_issue(input string name, input logic [31:0] inst, rd, op, sz, imm,
                                s1, s2, input int ack_delay);
        int n;
        n = 0;
        while (!iss_req) begin
            if (n == wait_limit) begin
                abort_run({"timeout waiting for iss_req at ", name});
            end
            step();
            n++;
        end
        check_eq({name, " inst_num"}, inst, iss_inst_num);
        check_eq({name, " rd"}, rd, iss_rd);
        check_eq({name, " op"}, op, iss_op);
        check_eq({name, " size"}, sz, iss_size);
        check_eq({name, " imm"}, imm, iss_imm);
        check_eq({name, " src1"}, s1, iss_src1);
        check_eq({name, " src2"}, s2, iss_src2);
        repeat (ack_delay) begin
            check_eq({name, " iss_req held for slow ack"}, 1, iss_req);
            step();
        end
        iss_ack = 1'b1;
        n = 0;
        do begin
            if (n == wait_limit) begin
                abort_run({"timeout waiting for iss_req to drop at ", name});
            end
            step();
            n++;
        end while (iss_req);
        iss_ack = 1'b0;
        step();
    endtask

    task automatic expect_quiet(input string name);
        repeat (20) begin
            check_eq({name, " iss_req stays low"}, 0, iss_req);
            step();
        end
    endtask

    initial begin
        int          fd;
        int          line_no;
        int          cnt;
        string       line;
        string       name;
        logic [31:0] inst, rd, op, sz, imm, s1, s2;
        logic [31:0] r1, r2, blk, bcv, bcp, bct, dly;
        clk           = 1'b0;
        rst_n         = 1'b0;
        flush         = 1'b0;
        disp_req      = 1'b0;
        disp_inst_num = '0;
        disp_rd       = '0;
        disp_op       = ls_inst_pkg::LS_LOAD;
        disp_size     = ls_inst_pkg::LS_WORD;
        disp_imm      = '0;
        disp_src1     = '0;
        disp_src2     = '0;
        disp_src1_rdy = 1'b0;
        disp_src2_rdy = 1'b0;
        wb_valid      = '0;
        wb_tag        = '0;
        iss_ack       = 1'b0;
        line_no       = 0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        fd = $fopen("rs_ls_golden.txt", "r");
        if (fd == 0) begin
            abort_run("could not open rs_ls_golden.txt");
        end
        while ($fgets(line, fd) > 0) begin
            line_no++;
            name = $sformatf("golden line %0d", line_no);
            case (line.getc(0))
                "#", "\n", "\r": ;
                "D": begin
                    cnt = $sscanf(line, "D %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                  inst, rd, op, sz, imm, s1, s2, r1, r2, blk, bcv, bcp, bct);
                    check_eq({name, " field count"}, 13, cnt);
                    disp_inst_num = inst[ls_inst_pkg::INST_NUM_W-1:0];
                    disp_rd       = rd[rs_cfg_pkg::TAG_W-1:0];
                    disp_op       = ls_inst_pkg::ls_op_e'(op[0]);
                    disp_size     = ls_inst_pkg::ls_size_e'(sz[2:0]);
                    disp_imm      = imm[ls_inst_pkg::IMM_W-1:0];
                    disp_src1     = s1[rs_cfg_pkg::TAG_W-1:0];
                    disp_src2     = s2[rs_cfg_pkg::TAG_W-1:0];
                    disp_src1_rdy = r1[0];
                    disp_src2_rdy = r2[0];
                    dispatch(name, blk[0], bcv[0], bcp, bct[rs_cfg_pkg::TAG_W-1:0]);
                end
                "W": begin
                    cnt = $sscanf(line, "W %h %h", bcp, bct);
                    check_eq({name, " field count"}, 2, cnt);
                    broadcast(bcp, bct[rs_cfg_pkg::TAG_W-1:0]);
                end
                "E": begin
                    cnt = $sscanf(line, "E %h %h %h %h %h %h %h %h",
                                  inst, rd, op, sz, imm, s1, s2, dly);
                    check_eq({name, " field count"}, 8, cnt);
                    expect_issue(name, inst, rd, op, sz, imm, s1, s2, dly);
                end
                "F": flush_station();
                "N": expect_quiet(name);
                default: abort_run({"unknown command letter at ", name});
            endcase
        end
        $fclose(fd);
        if (DUT.u_sva.fail_cnt == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            abort_run("a handshake assertion on the station failed");
        end
    end

endmodule

`default_nettype wire

//--- rs_ls_golden.txt
# D inst rd op size imm src1 src2 rdy1 rdy2 blocked bc_valid bc_port bc_tag (all hex)
# E inst rd op size imm src1 src2 ack_delay | W port tag | F flush | N no issue for 20 cycles
# ready at dispatch
D 0001 10 0 2 004 01 02 1 1 0 0 0 00
E 0001 10 0 2 004 01 02 0
# waiting source woken by a broadcast
D 0002 11 1 0 ff8 03 04 0 1 0 0 0 00
N
W 0 03
E 0002 11 1 0 ff8 03 04 0
# younger ready entry passes an older waiting one
D 0003 12 0 1 010 05 06 0 1 0 0 0 00
D 0004 13 0 4 014 07 08 1 1 0 0 0 00
E 0004 13 0 4 014 07 08 0
N
W 1 05
E 0003 12 0 1 010 05 06 2
# fifth entry sits outside the window
D 0005 14 0 2 020 09 40 0 1 0 0 0 00
D 0006 15 1 2 024 0a 41 0 1 0 0 0 00
D 0007 16 0 5 028 0b 42 0 1 0 0 0 00
D 0008 17 1 1 02c 0c 43 0 1 0 0 0 00
D 0009 18 0 0 030 0d 44 1 1 0 0 0 00
N
W 2 09
E 0005 14 0 2 020 09 40 5
E 0009 18 0 0 030 0d 44 0
W 0 0a
W 1 0b
W 2 0c
E 0006 15 1 2 024 0a 41 0
E 0007 16 0 5 028 0b 42 1
E 0008 17 1 1 02c 0c 43 0
# broadcast in the dispatch cycle
D 000a 19 0 2 034 0e 0f 0 1 0 1 1 0e
E 000a 19 0 2 034 0e 0f 0
# fill all sixteen entries with waiting loads and stores
D 0010 20 0 2 000 20 50 0 1 0 0 0 00
D 0011 21 1 2 004 21 50 0 1 0 0 0 00
D 0012 22 0 2 008 22 50 0 1 0 0 0 00
D 0013 23 1 2 00c 23 50 0 1 0 0 0 00
D 0014 24 0 0 010 24 50 0 1 0 0 0 00
D 0015 25 1 0 014 25 50 0 1 0 0 0 00
D 0016 26 0 1 018 26 50 0 1 0 0 0 00
D 0017 27 1 1 01c 27 50 0 1 0 0 0 00
D 0018 28 0 4 020 28 50 0 1 0 0 0 00
D 0019 29 0 5 024 29 50 0 1 0 0 0 00
D 001a 2a 1 2 028 2a 50 0 1 0 0 0 00
D 001b 2b 0 2 02c 2b 50 0 1 0 0 0 00
D 001c 2c 1 2 030 2c 50 0 1 0 0 0 00
D 001d 2d 0 2 034 2d 50 0 1 0 0 0 00
D 001e 2e 1 2 038 2e 50 0 1 0 0 0 00
D 001f 2f 0 2 03c 2f 50 0 1 0 0 0 00
N
D 0020 30 0 2 040 51 52 1 1 1 0 0 00
F
W 0 20
W 1 21
W 2 22
N
D 0021 31 1 0 7fc 53 54 1 1 0 0 0 00
E 0021 31 1 0 7fc 53 54 3

//--- sim.f
rs_cfg_pkg.sv
ls_inst_pkg.sv
rs_dispatch_in.sv
rs_entry_store.sv
rs_issue_out.sv
rs_ls_top.sv
rs_ls_sva.sv
tb_rs_ls.sv

//--- Bender.yml
package:
  name: rs_ls

sources:
  - rs_cfg_pkg.sv
  - ls_inst_pkg.sv
  - rs_dispatch_in.sv
  - rs_entry_store.sv
  - rs_issue_out.sv
  - rs_ls_top.sv
  - target: test
    files:
      - rs_ls_sva.sv
      - tb_rs_ls.sv
